/* simd_pkg.sv */
//////////////////////////////////////////////////
// Shared constants and types of the packed-SIMD ALU
// Opcodes, decoded control word and result word
//////////////////////////////////////////////////
`default_nettype none

package simd_pkg;

  localparam int XLEN     = 32;
  localparam int LANE8_W  = 8;
  localparam int LANE16_W = 16;
  localparam int SHAMT_W  = 5;

  // Saturation bounds
  localparam logic [LANE8_W-1:0]  SAT_S8_MAX  = 8'h7f;
  localparam logic [LANE8_W-1:0]  SAT_S8_MIN  = 8'h80;
  localparam logic [LANE8_W-1:0]  SAT_U8_MAX  = 8'hff;
  localparam logic [LANE16_W-1:0] SAT_S16_MAX = 16'h7fff;
  localparam logic [LANE16_W-1:0] SAT_S16_MIN = 16'h8000;
  localparam logic [LANE16_W-1:0] SAT_U16_MAX = 16'hffff;

  // 8-bit form on the even code, 16-bit form on the odd code
  typedef enum logic [5:0] {
    OP_ADD8,    OP_ADD16,    OP_SUB8,     OP_SUB16,
    OP_RADD8,   OP_RADD16,   OP_URADD8,   OP_URADD16,
    OP_RSUB8,   OP_RSUB16,   OP_URSUB8,   OP_URSUB16,
    OP_KADD8,   OP_KADD16,   OP_UKADD8,   OP_UKADD16,
    OP_KSUB8,   OP_KSUB16,   OP_UKSUB8,   OP_UKSUB16,
    OP_CMPEQ8,  OP_CMPEQ16,  OP_SCMPLT8,  OP_SCMPLT16,
    OP_SCMPLE8, OP_SCMPLE16, OP_UCMPLT8,  OP_UCMPLT16,
    OP_UCMPLE8, OP_UCMPLE16, OP_SMIN8,    OP_SMIN16,
    OP_SMAX8,   OP_SMAX16,   OP_UMIN8,    OP_UMIN16,
    OP_UMAX8,   OP_UMAX16,   OP_SRA8,     OP_SRA16,
    OP_SRL8,    OP_SRL16,    OP_SLL8,     OP_SLL16,
    OP_SRAI8,   OP_SRAI16,   OP_SRLI8,    OP_SRLI16,
    OP_SLLI8,   OP_SLLI16,   OP_CLZ8,     OP_CLZ16
  } simd_op_e;

  typedef enum logic {LANE_8, LANE_16} lane_w_e;

  typedef enum logic [1:0] {ADD_WRAP, ADD_HALVE, ADD_SAT} add_mode_e;

  typedef enum logic [2:0] {CMP_EQ, CMP_LT, CMP_LE, CMP_MIN, CMP_MAX} cmp_kind_e;

  typedef enum logic [1:0] {SH_SLL, SH_SRL, SH_SRA} shift_kind_e;

  typedef enum logic [2:0] {
    UNIT_ADD, UNIT_CMP, UNIT_MINMAX, UNIT_SHIFT, UNIT_CLZ
  } unit_e;

  // Decoded control, steers every lane unit
  typedef struct packed {
    lane_w_e     lane_w;
    logic        is_signed;
    logic        is_sub;
    add_mode_e   add_mode;
    cmp_kind_e   cmp_kind;
    shift_kind_e shift_kind;
    logic        use_imm;
    unit_e       unit;
  } simd_ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
    logic            ov;
  } simd_res_t;

endpackage

`default_nettype wire

/* simd_op_decode.sv */
//////////////////////////////////////////////////
// Opcode decoder, purely combinational
// Turns one SIMD opcode into the lane-unit controls
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module simd_op_decode (
  input  simd_pkg::simd_op_e   op_i,
  output simd_pkg::simd_ctrl_t ctrl_o
);

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.lane_w = simd_pkg::lane_w_e'(op_i[0]);

    // Result unit with its compare or shift flavor
    case (op_i)
      simd_pkg::OP_CMPEQ8, simd_pkg::OP_CMPEQ16: begin
        ctrl_o.unit     = simd_pkg::UNIT_CMP;
        ctrl_o.cmp_kind = simd_pkg::CMP_EQ;
      end
      simd_pkg::OP_SCMPLT8, simd_pkg::OP_SCMPLT16,
      simd_pkg::OP_UCMPLT8, simd_pkg::OP_UCMPLT16: begin
        ctrl_o.unit     = simd_pkg::UNIT_CMP;
        ctrl_o.cmp_kind = simd_pkg::CMP_LT;
      end
      simd_pkg::OP_SCMPLE8, simd_pkg::OP_SCMPLE16,
      simd_pkg::OP_UCMPLE8, simd_pkg::OP_UCMPLE16: begin
        ctrl_o.unit     = simd_pkg::UNIT_CMP;
        ctrl_o.cmp_kind = simd_pkg::CMP_LE;
      end
      simd_pkg::OP_SMIN8, simd_pkg::OP_SMIN16,
      simd_pkg::OP_UMIN8, simd_pkg::OP_UMIN16: begin
        ctrl_o.unit     = simd_pkg::UNIT_MINMAX;
        ctrl_o.cmp_kind = simd_pkg::CMP_MIN;
      end
      simd_pkg::OP_SMAX8, simd_pkg::OP_SMAX16,
      simd_pkg::OP_UMAX8, simd_pkg::OP_UMAX16: begin
        ctrl_o.unit     = simd_pkg::UNIT_MINMAX;
        ctrl_o.cmp_kind = simd_pkg::CMP_MAX;
      end
      simd_pkg::OP_SLL8, simd_pkg::OP_SLL16, simd_pkg::OP_SLLI8, simd_pkg::OP_SLLI16: begin
        ctrl_o.unit       = simd_pkg::UNIT_SHIFT;
        ctrl_o.shift_kind = simd_pkg::SH_SLL;
      end
      simd_pkg::OP_SRL8, simd_pkg::OP_SRL16, simd_pkg::OP_SRLI8, simd_pkg::OP_SRLI16: begin
        ctrl_o.unit       = simd_pkg::UNIT_SHIFT;
        ctrl_o.shift_kind = simd_pkg::SH_SRL;
      end
      simd_pkg::OP_SRA8, simd_pkg::OP_SRA16, simd_pkg::OP_SRAI8, simd_pkg::OP_SRAI16: begin
        ctrl_o.unit       = simd_pkg::UNIT_SHIFT;
        ctrl_o.shift_kind = simd_pkg::SH_SRA;
      end
      simd_pkg::OP_CLZ8, simd_pkg::OP_CLZ16: ctrl_o.unit = simd_pkg::UNIT_CLZ;
      default: ;
    endcase

    // Signed arithmetic and signed compares
    case (op_i)
      simd_pkg::OP_RADD8, simd_pkg::OP_RADD16, simd_pkg::OP_RSUB8, simd_pkg::OP_RSUB16,
      simd_pkg::OP_KADD8, simd_pkg::OP_KADD16, simd_pkg::OP_KSUB8, simd_pkg::OP_KSUB16,
      simd_pkg::OP_SCMPLT8, simd_pkg::OP_SCMPLT16, simd_pkg::OP_SCMPLE8, simd_pkg::OP_SCMPLE16,
      simd_pkg::OP_SMIN8, simd_pkg::OP_SMIN16, simd_pkg::OP_SMAX8, simd_pkg::OP_SMAX16:
        ctrl_o.is_signed = 1'b1;
      default: ;
    endcase

    case (op_i)
      simd_pkg::OP_RADD8, simd_pkg::OP_RADD16, simd_pkg::OP_URADD8, simd_pkg::OP_URADD16,
      simd_pkg::OP_RSUB8, simd_pkg::OP_RSUB16, simd_pkg::OP_URSUB8, simd_pkg::OP_URSUB16:
        ctrl_o.add_mode = simd_pkg::ADD_HALVE;
      simd_pkg::OP_KADD8, simd_pkg::OP_KADD16, simd_pkg::OP_UKADD8, simd_pkg::OP_UKADD16,
      simd_pkg::OP_KSUB8, simd_pkg::OP_KSUB16, simd_pkg::OP_UKSUB8, simd_pkg::OP_UKSUB16:
        ctrl_o.add_mode = simd_pkg::ADD_SAT;
      simd_pkg::OP_SLLI8, simd_pkg::OP_SLLI16, simd_pkg::OP_SRLI8, simd_pkg::OP_SRLI16,
      simd_pkg::OP_SRAI8, simd_pkg::OP_SRAI16:
        ctrl_o.use_imm = 1'b1;
      default: ;
    endcase

    // Compares and min/max need a minus b from the adder
    ctrl_o.is_sub = (ctrl_o.unit == simd_pkg::UNIT_CMP) ||
                    (ctrl_o.unit == simd_pkg::UNIT_MINMAX);
    case (op_i)
      simd_pkg::OP_SUB8, simd_pkg::OP_SUB16, simd_pkg::OP_RSUB8, simd_pkg::OP_RSUB16,
      simd_pkg::OP_URSUB8, simd_pkg::OP_URSUB16, simd_pkg::OP_KSUB8, simd_pkg::OP_KSUB16,
      simd_pkg::OP_UKSUB8, simd_pkg::OP_UKSUB16:
        ctrl_o.is_sub = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* simd_lane_adder.sv */
//////////////////////////////////////////////////
// Lane adder built from four chained byte adders
// Gives wrapping, halving or saturating results
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module simd_lane_adder (
  input  simd_pkg::simd_ctrl_t      ctrl_i,
  input  logic [simd_pkg::XLEN-1:0] operand_a_i,
  input  logic [simd_pkg::XLEN-1:0] operand_b_i,
  output logic [simd_pkg::XLEN-1:0] diff_o,
  output simd_pkg::simd_res_t       res_o
);

  logic                      lane16;
  logic [3:0][7:0]           a_byte;
  logic [3:0][7:0]           b_byte;
  logic                      carry1, carry3;
  logic [8:0]                sum0, sum1, sum2, sum3;
  logic [3:0][8:0]           byte_sum;
  logic [3:0]                top;
  logic [3:0]                clamp8;
  logic [1:0]                clamp16;
  logic [simd_pkg::XLEN-1:0] wrap_res;
  logic [simd_pkg::XLEN-1:0] halve8, halve16;
  logic [simd_pkg::XLEN-1:0] sat8, sat16;

  assign lane16 = (ctrl_i.lane_w == simd_pkg::LANE_16);
  assign a_byte = operand_a_i;
  assign b_byte = ctrl_i.is_sub ? ~operand_b_i : operand_b_i;

  //////////////////////////////////////////////////
  // Byte adders
  //////////////////////////////////////////////////
  // Carry only crosses the inner byte boundary of a 16-bit lane
  assign carry1 = lane16 ? sum0[8] : ctrl_i.is_sub;
  assign carry3 = lane16 ? sum2[8] : ctrl_i.is_sub;

  assign sum0 = {1'b0, a_byte[0]} + {1'b0, b_byte[0]} + {8'b0, ctrl_i.is_sub};
  assign sum1 = {1'b0, a_byte[1]} + {1'b0, b_byte[1]} + {8'b0, carry1};
  assign sum2 = {1'b0, a_byte[2]} + {1'b0, b_byte[2]} + {8'b0, ctrl_i.is_sub};
  assign sum3 = {1'b0, a_byte[3]} + {1'b0, b_byte[3]} + {8'b0, carry3};

  assign byte_sum = {sum3, sum2, sum1, sum0};
  assign wrap_res = {sum3[7:0], sum2[7:0], sum1[7:0], sum0[7:0]};
  assign diff_o   = wrap_res;

  // Bit n of the true (n+1)-bit result, from the extended operand bits
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      top[k] = (ctrl_i.is_signed & a_byte[k][7]) ^ byte_sum[k][8]
             ^ (ctrl_i.is_signed ? b_byte[k][7] : ctrl_i.is_sub);
    end
  end

  //////////////////////////////////////////////////
  // Halving and saturation
  //////////////////////////////////////////////////
  // Clamp when the true result does not fit the lane
  always_comb begin
    for (int k = 0; k < 4; k++) begin
      halve8[8*k +: 8] = {top[k], wrap_res[8*k+1 +: 7]};
      clamp8[k]        = top[k] ^ (ctrl_i.is_signed & wrap_res[8*k+7]);
      sat8[8*k +: 8]   = !clamp8[k]       ? wrap_res[8*k +: 8] :
                         ctrl_i.is_signed ? (top[k] ? simd_pkg::SAT_S8_MIN
                                                    : simd_pkg::SAT_S8_MAX) :
                         ctrl_i.is_sub    ? '0 : simd_pkg::SAT_U8_MAX;
    end
    for (int j = 0; j < 2; j++) begin
      halve16[16*j +: 16] = {top[2*j+1], wrap_res[16*j+1 +: 15]};
      clamp16[j]          = top[2*j+1] ^ (ctrl_i.is_signed & wrap_res[16*j+15]);
      sat16[16*j +: 16]   = !clamp16[j]      ? wrap_res[16*j +: 16] :
                            ctrl_i.is_signed ? (top[2*j+1] ? simd_pkg::SAT_S16_MIN
                                                           : simd_pkg::SAT_S16_MAX) :
                            ctrl_i.is_sub    ? '0 : simd_pkg::SAT_U16_MAX;
    end
  end

  always_comb begin
    case (ctrl_i.add_mode)
      simd_pkg::ADD_HALVE: res_o.data = lane16 ? halve16 : halve8;
      simd_pkg::ADD_SAT:   res_o.data = lane16 ? sat16 : sat8;
      default:             res_o.data = wrap_res;
    endcase
    res_o.ov = (ctrl_i.add_mode == simd_pkg::ADD_SAT) & (lane16 ? |clamp16 : |clamp8);
  end

endmodule

`default_nettype wire

/* simd_lane_compare.sv */
//////////////////////////////////////////////////
// Lane compare on the adder difference a minus b
// Drives compare masks and the min/max selection
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module simd_lane_compare (
  input  simd_pkg::simd_ctrl_t      ctrl_i,
  input  logic [simd_pkg::XLEN-1:0] operand_a_i,
  input  logic [simd_pkg::XLEN-1:0] operand_b_i,
  input  logic [simd_pkg::XLEN-1:0] diff_i,
  output logic [simd_pkg::XLEN-1:0] mask_o,
  output logic [simd_pkg::XLEN-1:0] minmax_o
);

  logic       lane16;
  logic [3:0] eq_byte, lt_byte;
  logic [3:0] eq_lane, lt_lane;
  logic [3:0] pick;

  assign lane16 = (ctrl_i.lane_w == simd_pkg::LANE_16);

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      eq_byte[k] = (diff_i[8*k +: 8] == 8'h00);
      // Equal signs cannot overflow, so the difference sign decides
      lt_byte[k] = (operand_a_i[8*k+7] == operand_b_i[8*k+7]) ? diff_i[8*k+7]
                 : operand_a_i[8*k+7] ^ ~ctrl_i.is_signed;
    end
  end

  // One bit per byte, repeated over each 16-bit lane
  assign eq_lane = lane16 ? {{2{&eq_byte[3:2]}}, {2{&eq_byte[1:0]}}} : eq_byte;
  assign lt_lane = lane16 ? {{2{lt_byte[3]}}, {2{lt_byte[1]}}} : lt_byte;

  always_comb begin
    case (ctrl_i.cmp_kind)
      simd_pkg::CMP_LT:  pick = lt_lane;
      simd_pkg::CMP_LE:  pick = lt_lane | eq_lane;
      simd_pkg::CMP_MIN: pick = lt_lane;
      simd_pkg::CMP_MAX: pick = ~lt_lane;
      default:           pick = eq_lane;
    endcase
  end

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      mask_o[8*k +: 8]   = {8{pick[k]}};
      minmax_o[8*k +: 8] = pick[k] ? operand_a_i[8*k +: 8] : operand_b_i[8*k +: 8];
    end
  end

endmodule

`default_nettype wire

/* simd_lane_shifter.sv */
//////////////////////////////////////////////////
// Lane shifter for logical and arithmetic shifts
// Left shifts run right on the bit-reversed word
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module simd_lane_shifter (
  input  simd_pkg::simd_ctrl_t         ctrl_i,
  input  logic [simd_pkg::XLEN-1:0]    operand_a_i,
  input  logic [simd_pkg::XLEN-1:0]    operand_b_i,
  input  logic [simd_pkg::SHAMT_W-1:0] imm_i,
  output logic [simd_pkg::XLEN-1:0]    result_o
);

  logic                          lane16;
  logic                          shift_left;
  logic                          arith;
  logic [simd_pkg::SHAMT_W-1:0]  amt_raw;
  logic [3:0]                    amt;
  logic [simd_pkg::LANE8_W-1:0]  mask8;
  logic [simd_pkg::LANE16_W-1:0] mask16;
  logic [3:0]                    lane_sign;
  logic [simd_pkg::XLEN-1:0]     src, shifted, lane_mask, res;

  assign lane16     = (ctrl_i.lane_w == simd_pkg::LANE_16);
  assign shift_left = (ctrl_i.shift_kind == simd_pkg::SH_SLL);
  assign arith      = (ctrl_i.shift_kind == simd_pkg::SH_SRA);

  // Amount modulo the lane width
  assign amt_raw = ctrl_i.use_imm ? imm_i : operand_b_i[simd_pkg::SHAMT_W-1:0];
  assign amt     = lane16 ? amt_raw[3:0] : {1'b0, amt_raw[2:0]};

  always_comb begin
    for (int i = 0; i < simd_pkg::XLEN; i++) begin
      src[i] = shift_left ? operand_a_i[simd_pkg::XLEN-1-i] : operand_a_i[i];
    end
  end

  assign shifted = src >> amt;

  // Thermometer mask drops bits pulled in from the next lane up
  assign mask8     = {simd_pkg::LANE8_W{1'b1}} >> amt;
  assign mask16    = {simd_pkg::LANE16_W{1'b1}} >> amt;
  assign lane_mask = lane16 ? {2{mask16}} : {4{mask8}};

  // Sign of each lane, one bit per byte
  assign lane_sign = !arith ? 4'b0000 :
                     lane16 ? {{2{src[31]}}, {2{src[15]}}} :
                              {src[31], src[23], src[15], src[7]};

  always_comb begin
    for (int i = 0; i < simd_pkg::XLEN; i++) begin
      res[i] = (shifted[i] & lane_mask[i]) | (lane_sign[i/8] & ~lane_mask[i]);
    end
    for (int i = 0; i < simd_pkg::XLEN; i++) begin
      result_o[i] = shift_left ? res[simd_pkg::XLEN-1-i] : res[i];
    end
  end

endmodule

`default_nettype wire

/* simd_lane_clz.sv */
//////////////////////////////////////////////////
// Per-lane count-leading-zeros
// Prefix chain feeding a popcount adder tree
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module simd_lane_clz (
  input  simd_pkg::simd_ctrl_t      ctrl_i,
  input  logic [simd_pkg::XLEN-1:0] operand_a_i,
  output logic [simd_pkg::XLEN-1:0] result_o
);

  logic                      lane16;
  logic [simd_pkg::XLEN-1:0] lead;
  logic [15:0][1:0]          cnt2;
  logic [7:0][2:0]           cnt4;
  logic [3:0][3:0]           cnt8;
  logic [1:0][4:0]           cnt16;

  assign lane16 = (ctrl_i.lane_w == simd_pkg::LANE_16);

  // Leading ones of the inverted operand, restarted at every lane top
  always_comb begin
    logic lane_top;
    lead[simd_pkg::XLEN-1] = ~operand_a_i[simd_pkg::XLEN-1];
    for (int i = simd_pkg::XLEN-2; i >= 0; i--) begin
      lane_top = (i % 8 == 7) && (!lane16 || (i % 16 == 15));
      lead[i]  = ~operand_a_i[i] & (lane_top | lead[i+1]);
    end
  end

  // Popcount tree, byte and halfword layers are the lane counts
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      cnt2[i] = {1'b0, lead[2*i]} + {1'b0, lead[2*i+1]};
    end
    for (int i = 0; i < 8; i++) begin
      cnt4[i] = {1'b0, cnt2[2*i]} + {1'b0, cnt2[2*i+1]};
    end
    for (int i = 0; i < 4; i++) begin
      cnt8[i] = {1'b0, cnt4[2*i]} + {1'b0, cnt4[2*i+1]};
    end
    for (int i = 0; i < 2; i++) begin
      cnt16[i] = {1'b0, cnt8[2*i]} + {1'b0, cnt8[2*i+1]};
    end
  end

  assign result_o = lane16 ? {11'b0, cnt16[1], 11'b0, cnt16[0]}
                           : {4'b0, cnt8[3], 4'b0, cnt8[2], 4'b0, cnt8[1], 4'b0, cnt8[0]};

endmodule

`default_nettype wire

/* simd_result_sel.sv */
//////////////////////////////////////////////////
// Result stage, picks the unit output and
// registers it with the overflow flag and valid
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module simd_result_sel (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      valid_i,
  input  simd_pkg::simd_ctrl_t      ctrl_i,
  input  simd_pkg::simd_res_t       add_res_i,
  input  logic [simd_pkg::XLEN-1:0] cmp_mask_i,
  input  logic [simd_pkg::XLEN-1:0] minmax_i,
  input  logic [simd_pkg::XLEN-1:0] shift_i,
  input  logic [simd_pkg::XLEN-1:0] clz_i,
  output logic                      valid_o,
  output simd_pkg::simd_res_t       res_o
);

  simd_pkg::simd_res_t sel_res;

  // Only the adder raises ov
  always_comb begin
    sel_res = '0;
    case (ctrl_i.unit)
      simd_pkg::UNIT_ADD:    sel_res      = add_res_i;
      simd_pkg::UNIT_CMP:    sel_res.data = cmp_mask_i;
      simd_pkg::UNIT_MINMAX: sel_res.data = minmax_i;
      simd_pkg::UNIT_SHIFT:  sel_res.data = shift_i;
      simd_pkg::UNIT_CLZ:    sel_res.data = clz_i;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      res_o   <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        res_o <= sel_res;
      end
    end
  end

endmodule

`default_nettype wire

/* simd_alu_top.sv */
//////////////////////////////////////////////////
// Packed-SIMD ALU top, one pipeline stage
// Strobe valid_i, result arrives one cycle later
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module simd_alu_top (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         valid_i,
  input  simd_pkg::simd_op_e           op_i,
  input  logic [simd_pkg::XLEN-1:0]    operand_a_i,
  input  logic [simd_pkg::XLEN-1:0]    operand_b_i,
  input  logic [simd_pkg::SHAMT_W-1:0] imm_i,
  output logic                         valid_o,
  output logic [simd_pkg::XLEN-1:0]    result_o,
  output logic                         ov_o
);

  simd_pkg::simd_ctrl_t      ctrl;
  simd_pkg::simd_res_t       add_res;
  simd_pkg::simd_res_t       res;
  logic [simd_pkg::XLEN-1:0] diff;
  logic [simd_pkg::XLEN-1:0] cmp_mask;
  logic [simd_pkg::XLEN-1:0] minmax;
  logic [simd_pkg::XLEN-1:0] shift_res;
  logic [simd_pkg::XLEN-1:0] clz_res;

  simd_op_decode u_decode (
    .op_i   (op_i),
    .ctrl_o (ctrl)
  );

  //////////////////////////////////////////////////
  // Lane units
  //////////////////////////////////////////////////
  simd_lane_adder u_adder (
    .ctrl_i      (ctrl),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .diff_o      (diff),
    .res_o       (add_res)
  );

  simd_lane_compare u_compare (
    .ctrl_i      (ctrl),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .diff_i      (diff),
    .mask_o      (cmp_mask),
    .minmax_o    (minmax)
  );

  simd_lane_shifter u_shifter (
    .ctrl_i      (ctrl),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .imm_i       (imm_i),
    .result_o    (shift_res)
  );

  simd_lane_clz u_clz (
    .ctrl_i      (ctrl),
    .operand_a_i (operand_a_i),
    .result_o    (clz_res)
  );

  // Output register
  simd_result_sel u_result (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .ctrl_i     (ctrl),
    .add_res_i  (add_res),
    .cmp_mask_i (cmp_mask),
    .minmax_i   (minmax),
    .shift_i    (shift_res),
    .clz_i      (clz_res),
    .valid_o    (valid_o),
    .res_o      (res)
  );

  assign result_o = res.data;
  assign ov_o     = res.ov;

endmodule

`default_nettype wire

/* tb_simd_alu.sv */
//////////////////////////////////////////////////
// Self-checking testbench for the packed-SIMD ALU
// Issues every opcode on edge and LCG operands and
// checks each registered result against a lane model
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_simd_alu;

  logic                         clk_i = 1'b0;
  logic                         rst_i;
  logic                         valid_i;
  simd_pkg::simd_op_e           op_i;
  logic [simd_pkg::XLEN-1:0]    operand_a_i;
  logic [simd_pkg::XLEN-1:0]    operand_b_i;
  logic [simd_pkg::SHAMT_W-1:0] imm_i;
  logic                         valid_o;
  logic [simd_pkg::XLEN-1:0]    result_o;
  logic                         ov_o;

  simd_pkg::simd_res_t exp_q [$];
  string               tag_q [$];
  logic                valid_expect = 1'b0;
  logic [31:0]         lcg_state = 32'd66;
  int                  checks = 0;
  int                  errors = 0;

  simd_alu_top uut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .imm_i       (imm_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .ov_o        (ov_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic int lane_width(simd_pkg::simd_op_e op);
    string n;
    n = op.name();
    return (n.substr(n.len() - 2, n.len() - 1) == "16") ? 16 : 8;
  endfunction

  // Mnemonic without the OP_ prefix and the width suffix
  function automatic string base_name(simd_pkg::simd_op_e op);
    string n;
    n = op.name();
    return n.substr(3, n.len() - 1 - lane_width(op) / 8);
  endfunction

  function automatic int op_group(simd_pkg::simd_op_e op);
    string b;
    b = base_name(op);
    if (b == "SRA" || b == "SRL" || b == "SLL" || b == "SRAI" || b == "SRLI" || b == "SLLI")
      return 2;
    if (b == "CLZ")
      return 3;
    if (b == "CMPEQ" || b == "SCMPLT" || b == "SCMPLE" || b == "UCMPLT" || b == "UCMPLE" ||
        b == "SMIN" || b == "SMAX" || b == "UMIN" || b == "UMAX")
      return 1;
    return 0;
  endfunction

  function automatic longint saturate(longint v, longint lo, longint hi);
    if (v > hi) return hi;
    if (v < lo) return lo;
    return v;
  endfunction

  function automatic simd_pkg::simd_res_t ref_result(simd_pkg::simd_op_e op,
                                                     logic [31:0] a, logic [31:0] b,
                                                     logic [4:0] imm);
    simd_pkg::simd_res_t res;
    string  base;
    int     w;
    int     amt;
    logic   found;
    longint lim, smax, smin, ua, ub, sa, sb, v, r;
    res  = '0;
    base = base_name(op);
    w    = lane_width(op);
    lim  = longint'(1) << w;
    smax = (lim >> 1) - 1;
    smin = -(lim >> 1);
    if (base == "SRAI" || base == "SRLI" || base == "SLLI")
      amt = int'(imm) % w;
    else
      amt = int'(b[4:0]) % w;
    for (int l = 0; l < 32 / w; l++) begin
      ua = longint'(a >> (l * w)) & (lim - 1);
      ub = longint'(b >> (l * w)) & (lim - 1);
      sa = (ua > smax) ? ua - lim : ua;
      sb = (ub > smax) ? ub - lim : ub;
      r  = longint'(0);
      v  = longint'(0);
      if (base == "ADD") r = ua + ub;
      else if (base == "SUB") r = ua - ub;
      else if (base == "RADD") r = (sa + sb) >>> 1;
      else if (base == "URADD") r = (ua + ub) >>> 1;
      else if (base == "RSUB") r = (sa - sb) >>> 1;
      else if (base == "URSUB") r = (ua - ub) >>> 1;
      else if (base == "KADD" || base == "KSUB" || base == "UKADD" || base == "UKSUB") begin
        // Exact lane result, then clamp to the lane range
        if (base == "KADD") v = sa + sb;
        else if (base == "KSUB") v = sa - sb;
        else if (base == "UKADD") v = ua + ub;
        else v = ua - ub;
        if (base[0] == "U") r = saturate(v, longint'(0), lim - 1);
        else r = saturate(v, smin, smax);
        if (r != v) res.ov = 1'b1;
      end
      else if (base == "CMPEQ") r = (ua == ub) ? lim - 1 : longint'(0);
      else if (base == "SCMPLT") r = (sa < sb) ? lim - 1 : longint'(0);
      else if (base == "SCMPLE") r = (sa <= sb) ? lim - 1 : longint'(0);
      else if (base == "UCMPLT") r = (ua < ub) ? lim - 1 : longint'(0);
      else if (base == "UCMPLE") r = (ua <= ub) ? lim - 1 : longint'(0);
      else if (base == "SMIN") r = (sa < sb) ? ua : ub;
      else if (base == "SMAX") r = (sa > sb) ? ua : ub;
      else if (base == "UMIN") r = (ua < ub) ? ua : ub;
      else if (base == "UMAX") r = (ua > ub) ? ua : ub;
      else if (base == "SRA" || base == "SRAI") r = sa >>> amt;
      else if (base == "SRL" || base == "SRLI") r = ua >> amt;
      else if (base == "SLL" || base == "SLLI") r = ua << amt;
      else begin
        // Leading zeros, a zero lane counts the full width
        r     = longint'(w);
        found = 1'b0;
        for (int bit_idx = w - 1; bit_idx >= 0; bit_idx--) begin
          if (!found && ua[bit_idx]) begin
            r     = longint'(w - 1 - bit_idx);
            found = 1'b1;
          end
        end
      end
      res.data = res.data | 32'((r & (lim - 1)) << (l * w));
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks and the checking process
  //////////////////////////////////////////////////
  task automatic check_data(input string tag, input logic [simd_pkg::XLEN-1:0] got,
                            input logic [simd_pkg::XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t result_o got %08h expected %08h (%s)", $time, got, exp, tag);
    end
  endtask

  task automatic check_ov(input string tag, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t ov_o got %b expected %b (%s)", $time, got, exp, tag);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t valid_o got %b expected %b", $time, got, exp);
    end
  endtask

  // One-cycle pipeline, valid_o follows valid_i by one edge
  always @(posedge clk_i) begin
    valid_expect <= rst_i ? 1'b0 : valid_i;
  end

  // Outputs sampled mid-cycle where they are stable
  always @(negedge clk_i) begin : compare_proc
    simd_pkg::simd_res_t expected;
    string               tag;
    if (!rst_i) begin
      check_valid(valid_o, valid_expect);
      if (valid_o) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Result seen at t=%0t with no operation outstanding", $time);
        end else begin
          expected = exp_q.pop_front();
          tag      = tag_q.pop_front();
          check_data(tag, result_o, expected.data);
          check_ov(tag, ov_o, expected.ov);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  function automatic void edge_pair(input int i, output logic [31:0] a, output logic [31:0] b);
    case (i)
      0:       begin a = 32'h7f7f7f7f; b = 32'h01010101; end
      1:       begin a = 32'h80008000; b = 32'h00010001; end
      2:       begin a = 32'h7fff7fff; b = 32'h00010001; end
      3:       begin a = 32'hffffffff; b = 32'h01010101; end
      4:       begin a = 32'h00000000; b = 32'hffffffff; end
      5:       begin a = 32'h80808080; b = 32'h7f7f7f7f; end
      6:       begin a = 32'h12345678; b = 32'h12345678; end
      default: begin a = 32'h00ff0100; b = 32'h0000000f; end
    endcase
  endfunction

  task automatic issue(input simd_pkg::simd_op_e op, input logic [31:0] a,
                       input logic [31:0] b, input logic [4:0] imm);
    @(posedge clk_i);
    valid_i     <= 1'b1;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    imm_i       <= imm;
    exp_q.push_back(ref_result(op, a, b, imm));
    tag_q.push_back(op.name());
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < 20) begin
      @(posedge clk_i);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timeout, %0d results never arrived on valid_o", exp_q.size());
      exp_q.delete();
      tag_q.delete();
    end
  endtask

  task automatic check_reset_state();
    int err_start;
    err_start = errors;
    repeat (4) @(negedge clk_i);
    check_data("after reset", result_o, '0);
    check_ov("after reset", ov_o, 1'b0);
    $display("test %-16s %0d errors", "reset", errors - err_start);
  endtask

  // Every opcode of a group, issued back to back
  task automatic run_group(input int group, input string label);
    simd_pkg::simd_op_e op;
    logic [31:0]        ra, rb, rc;
    int                 err_start;
    int                 ops;
    err_start = errors;
    ops       = 0;
    op        = op.first();
    for (int k = 0; k < op.num(); k++) begin
      if (op_group(op) == group) begin
        for (int i = 0; i < 8; i++) begin
          edge_pair(i, ra, rb);
          issue(op, ra, rb, 5'(i * 5));
          ops++;
        end
        for (int i = 0; i < 24; i++) begin
          ra = next_rand();
          rb = next_rand();
          rc = next_rand();
          issue(op, ra, rb, rc[4:0]);
          ops++;
        end
      end
      op = op.next();
    end
    go_idle();
    wait_drain();
    $display("test %-16s %0d ops, %0d errors", label, ops, errors - err_start);
  endtask

  initial begin
    rst_i       = 1'b1;
    valid_i     = 1'b0;
    op_i        = simd_pkg::OP_ADD8;
    operand_a_i = '0;
    operand_b_i = '0;
    imm_i       = '0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    check_reset_state();
    run_group(0, "add/sub");
    run_group(1, "compare/minmax");
    run_group(2, "shift");
    run_group(3, "clz");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
simd_pkg.sv
simd_op_decode.sv
simd_lane_adder.sv
simd_lane_compare.sv
simd_lane_shifter.sv
simd_lane_clz.sv
simd_result_sel.sv
simd_alu_top.sv
tb_simd_alu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SIMD ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_simd_alu -f tb.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_simd_alu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0
